// File: dct_rot_pkg.sv
/*
 * shared definitions for the dct rotation reorder buffer
 * widths, sample and complex types, index and bank address types
 * frame info, read tag and output pair beat structs
 * write and read controller state encodings
 */
`default_nettype none

package dct_rot_pkg;

	// ------------------------------------------------------------
	// widths
	// ------------------------------------------------------------
	// one real or imaginary part
	localparam int SAMPLE_W = 28;
	// frame size range, 32 to 2048 points
	localparam int MAX_LOG2 = 11;
	localparam int MIN_LOG2 = 5;
	// each bank holds half a max frame
	localparam int BANK_AW  = MAX_LOG2 - 1;

	// ------------------------------------------------------------
	// data types
	// ------------------------------------------------------------
	typedef logic signed [SAMPLE_W-1:0] sample_t;

	typedef struct packed {
		sample_t re;
		sample_t im;
	} cplx_t;

	// natural sample index
	typedef logic [MAX_LOG2-1:0] idx_t;
	typedef logic [BANK_AW-1:0] bank_addr_t;
	// log2 of the point count
	typedef logic [3:0] size_log2_t;

	// pulsed by the write side once a frame is stored
	typedef struct packed {
		size_log2_t size_log2;
		logic start;
	} frame_info_t;

	// travels alongside a read, one cycle behind the address
	typedef struct packed {
		logic fwd_bank;
		logic rev_bank;
		logic sop;
		logic eop;
	} rd_tag_t;

	// output beat, F(k) and F((N-k) mod N)
	typedef struct packed {
		cplx_t fwd;
		cplx_t rev;
		logic sop;
		logic eop;
	} pair_beat_t;

	// ------------------------------------------------------------
	// FSM encodings
	// ------------------------------------------------------------
	typedef enum logic [1:0] {WR_IDLE, WR_FILL, WR_HOLD} wr_state_t;
	typedef enum logic {RD_IDLE, RD_RUN} rd_state_t;

endpackage

`default_nettype wire

// File: dct_rot_bank_ram.sv
/*
 * one storage bank of the reorder buffer
 * simple dual port, synchronous write, registered read
 */
`default_nettype none

module dct_rot_bank_ram #(
	parameter int DEPTH_LOG2 = 10,
	parameter int WORD_W = 56
) (
	input  wire                   clk,
	input  wire                   we,
	input  wire  [DEPTH_LOG2-1:0] waddr,
	input  wire  [WORD_W-1:0]     wdata,
	input  wire  [DEPTH_LOG2-1:0] raddr,
	output logic [WORD_W-1:0]     rdata
);

	localparam int DEPTH = 1 << DEPTH_LOG2;

	// storage array
	logic [WORD_W-1:0] mem [DEPTH];

	// write port
	always_ff @(posedge clk)
	begin
		if (we)
			mem[waddr] <= wdata;
	end

	// read port, data one cycle after the address
	always_ff @(posedge clk)
	begin
		rdata <= mem[raddr];
	end

	// writes land inside the bank, no x on the address
	assert property (@(posedge clk) we |-> (!$isunknown(waddr) && (waddr < DEPTH)));

endmodule

`default_nettype wire

// File: dct_rot_write_ctrl.sv
/*
 * input side of the reorder buffer
 * sink handshake, frame size latch, arrival counter
 * bit reversed write address and bank steering
 * frame hand-off to the read side
 */
`default_nettype none

module dct_rot_write_ctrl
	import dct_rot_pkg::*;
(
	input  wire         clk,
	input  wire         rst_n_sync,
	input  wire         sink_valid,
	output logic        sink_ready,
	input  wire         sink_sop,
	input  cplx_t       sink_data,
	input  size_log2_t  fft_size_log2,
	input  wire         read_done,
	output logic        we0,
	output logic        we1,
	output bank_addr_t  waddr0,
	output bank_addr_t  waddr1,
	output cplx_t       wdata,
	output frame_info_t frame_info
);

	wr_state_t state;
	size_log2_t size_q;
	idx_t cnt;
	logic info_start;

	logic accept;
	logic wr_en;
	logic last;
	logic [MAX_LOG2:0] frame_n;
	idx_t half;
	idx_t rev;
	bank_addr_t addr;

	// reverse the low l bits of c, upper bits zero
	function automatic idx_t bit_rev(idx_t c, size_log2_t l);
		idx_t r;
		r = '0;
		for (int j = 0; j < MAX_LOG2; j++)
		begin
			if (j < l)
				r[j] = c[l - 1 - j];
		end
		return r;
	endfunction

	// ------------------------------------------------------------
	// write path
	// ------------------------------------------------------------
	assign accept = sink_valid && sink_ready;
	// a frame opens on sop, stray beats in idle are dropped
	assign wr_en = accept && ((state == WR_FILL) || ((state == WR_IDLE) && sink_sop));

	assign frame_n = (MAX_LOG2 + 1)'(1) << size_q;
	assign half = idx_t'(frame_n >> 1);
	assign last = (cnt == idx_t'(frame_n - 1'b1));

	// count is zero in idle, so the first sample always goes to index 0
	assign rev = bit_rev(cnt, size_q);
	// top bit of the reversed index picks the bank
	assign addr = bank_addr_t'(rev & (half - 1'b1));

	assign we0 = wr_en && !(|(rev & half));
	assign we1 = wr_en && (|(rev & half));
	assign waddr0 = addr;
	assign waddr1 = addr;
	assign wdata = sink_data;

	assign frame_info = '{size_log2: size_q, start: info_start};

	// ------------------------------------------------------------
	// FSM
	// ------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n_sync)
		begin
			state <= WR_IDLE;
			sink_ready <= 1'b0;
			size_q <= size_log2_t'(MIN_LOG2);
			cnt <= '0;
			info_start <= 1'b0;
		end
		else
		begin
			info_start <= 1'b0;
			case (state)
				WR_IDLE:
				begin
					sink_ready <= 1'b1;
					if (accept && sink_sop)
					begin
						size_q <= fft_size_log2;
						cnt <= idx_t'(1);
						state <= WR_FILL;
					end
				end
				WR_FILL:
				begin
					if (accept)
					begin
						if (last)
						begin
							// frame complete, stop the sink and hand off
							cnt <= '0;
							sink_ready <= 1'b0;
							info_start <= 1'b1;
							state <= WR_HOLD;
						end
						else
							cnt <= cnt + 1'b1;
					end
				end
				WR_HOLD:
				begin
					// banks busy until the last read is out
					if (read_done)
					begin
						sink_ready <= 1'b1;
						state <= WR_IDLE;
					end
				end
				default:
				begin
					sink_ready <= 1'b0;
					state <= WR_IDLE;
				end
			endcase
		end
	end

	// latched frame size within the supported range
	assert property (@(posedge clk) disable iff (!rst_n_sync)
		(state != WR_IDLE) |-> (size_q inside {[MIN_LOG2:MAX_LOG2]}));

endmodule

`default_nettype wire

// File: dct_rot_read_ctrl.sv
/*
 * read side of the reorder buffer
 * forward and reverse index generation per output beat
 * bank address and tag forming, frame flags
 * credit counter against the two entry output buffer
 */
`default_nettype none

module dct_rot_read_ctrl
	import dct_rot_pkg::*;
(
	input  wire         clk,
	input  wire         rst_n_sync,
	input  frame_info_t frame_info,
	input  wire         pop,
	output bank_addr_t  raddr0,
	output bank_addr_t  raddr1,
	output rd_tag_t     tag,
	output logic        push,
	output logic        read_done
);

	rd_state_t state;
	size_log2_t size_q;
	idx_t k;
	logic [1:0] credit;

	logic issue;
	logic last;
	logic [MAX_LOG2:0] frame_n;
	idx_t mask;
	idx_t half;
	idx_t rev_idx;
	logic fwd_bank;
	logic rev_bank;
	bank_addr_t fwd_addr;
	bank_addr_t rev_addr;

	// ------------------------------------------------------------
	// index and address forming
	// ------------------------------------------------------------
	assign frame_n = (MAX_LOG2 + 1)'(1) << size_q;
	assign mask = idx_t'(frame_n - 1'b1);
	assign half = idx_t'(frame_n >> 1);

	// (N-k) mod N
	assign rev_idx = (idx_t'(0) - k) & mask;

	// upper half of the indices lives in bank 1
	assign fwd_bank = |(k & half);
	assign rev_bank = |(rev_idx & half);
	assign fwd_addr = bank_addr_t'(k & (half - 1'b1));
	assign rev_addr = bank_addr_t'(rev_idx & (half - 1'b1));

	// banks differ except at k = 0 and k = N/2
	// there both indices are equal, same bank and same address
	assign raddr0 = fwd_bank ? rev_addr : fwd_addr;
	assign raddr1 = fwd_bank ? fwd_addr : rev_addr;

	// one read per free slot downstream
	assign issue = (state == RD_RUN) && (credit != 2'd0);
	assign last = (k == mask);

	// ------------------------------------------------------------
	// FSM, beat index and credit
	// ------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n_sync)
		begin
			state <= RD_IDLE;
			size_q <= size_log2_t'(MIN_LOG2);
			k <= '0;
			credit <= 2'd2;
			push <= 1'b0;
			read_done <= 1'b0;
		end
		else
		begin
			// returned slots minus consumed ones
			credit <= credit - {1'b0, issue} + {1'b0, pop};
			push <= issue;
			read_done <= issue && last;
			case (state)
				RD_IDLE:
				begin
					if (frame_info.start)
					begin
						size_q <= frame_info.size_log2;
						k <= '0;
						state <= RD_RUN;
					end
				end
				RD_RUN:
				begin
					if (issue)
					begin
						k <= k + 1'b1;
						if (last)
							state <= RD_IDLE;
					end
				end
				default:
					state <= RD_IDLE;
			endcase
		end
	end

	// tag lines up with the registered bank data
	always_ff @(posedge clk)
	begin
		if (issue)
		begin
			tag.fwd_bank <= fwd_bank;
			tag.rev_bank <= rev_bank;
			tag.sop <= (k == '0);
			tag.eop <= last;
		end
	end

	// pops never return more than was handed out
	assert property (@(posedge clk) disable iff (!rst_n_sync) credit <= 2'd2);

endmodule

`default_nettype wire

// File: dct_rot_out_buf.sv
/*
 * output side of the reorder buffer
 * pair forming from the two bank outputs
 * two entry valid/ready buffer toward the source
 */
`default_nettype none

module dct_rot_out_buf
	import dct_rot_pkg::*;
(
	input  wire        clk,
	input  wire        rst_n_sync,
	input  wire        push,
	input  rd_tag_t    tag,
	input  cplx_t      rdata0,
	input  cplx_t      rdata1,
	output logic       source_valid,
	input  wire        source_ready,
	output pair_beat_t source_data,
	output logic       pop
);

	pair_beat_t mem [2];
	pair_beat_t beat;
	logic [1:0] count;
	logic wr_ptr;
	logic rd_ptr;

	// ------------------------------------------------------------
	// pair forming
	// ------------------------------------------------------------
	// each half comes from the bank named in the tag
	assign beat.fwd = tag.fwd_bank ? rdata1 : rdata0;
	assign beat.rev = tag.rev_bank ? rdata1 : rdata0;
	assign beat.sop = tag.sop;
	assign beat.eop = tag.eop;

	// ------------------------------------------------------------
	// two entry buffer
	// ------------------------------------------------------------
	assign source_valid = (count != 2'd0);
	// head entry is never written while occupied
	assign source_data = mem[rd_ptr];
	// a pop also hands a credit back to the read side
	assign pop = source_valid && source_ready;

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= beat;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n_sync)
		begin
			count <= 2'd0;
			wr_ptr <= 1'b0;
			rd_ptr <= 1'b0;
		end
		else
		begin
			if (push)
				wr_ptr <= ~wr_ptr;
			if (pop)
				rd_ptr <= ~rd_ptr;
			count <= count + {1'b0, push} - {1'b0, pop};
		end
	end

	// credit flow keeps the buffer from overflowing
	assert property (@(posedge clk) disable iff (!rst_n_sync) push |-> (count != 2'd2));

	// stalled beat held unchanged
	assert property (@(posedge clk) disable iff (!rst_n_sync)
		(source_valid && !source_ready) |=> (source_valid && $stable(source_data)));

endmodule

`default_nettype wire

// File: dct_rot_top.sv
/*
 * top level of the dct rotation reorder buffer
 * write controller, two storage banks, read controller
 * and the output pair buffer
 */
`default_nettype none

module dct_rot_top
	import dct_rot_pkg::*;
(
	input  wire        clk,
	input  wire        rst_n_sync,
	// sink, bit reversed fft output
	input  wire        sink_valid,
	output logic       sink_ready,
	input  wire        sink_sop,
	input  cplx_t      sink_data,
	input  size_log2_t fft_size_log2,
	// source, paired natural order beats
	output logic       source_valid,
	input  wire        source_ready,
	output pair_beat_t source_data
);

	// write side to banks
	logic we0;
	logic we1;
	bank_addr_t waddr0;
	bank_addr_t waddr1;
	cplx_t wdata;

	// frame hand-off
	frame_info_t frame_info;
	logic read_done;

	// read side
	bank_addr_t raddr0;
	bank_addr_t raddr1;
	cplx_t rdata0;
	cplx_t rdata1;
	rd_tag_t tag;
	logic push;
	logic pop;

	// ------------------------------------------------------------
	// input side
	// ------------------------------------------------------------
	dct_rot_write_ctrl i_write_ctrl (
		.clk           (clk),
		.rst_n_sync    (rst_n_sync),
		.sink_valid    (sink_valid),
		.sink_ready    (sink_ready),
		.sink_sop      (sink_sop),
		.sink_data     (sink_data),
		.fft_size_log2 (fft_size_log2),
		.read_done     (read_done),
		.we0           (we0),
		.we1           (we1),
		.waddr0        (waddr0),
		.waddr1        (waddr1),
		.wdata         (wdata),
		.frame_info    (frame_info)
	);

	// ------------------------------------------------------------
	// banks, lower and upper half of the indices
	// ------------------------------------------------------------
	dct_rot_bank_ram #(
		.DEPTH_LOG2 (BANK_AW),
		.WORD_W     ($bits(cplx_t))
	) i_bank0 (
		.clk   (clk),
		.we    (we0),
		.waddr (waddr0),
		.wdata (wdata),
		.raddr (raddr0),
		.rdata (rdata0)
	);

	dct_rot_bank_ram #(
		.DEPTH_LOG2 (BANK_AW),
		.WORD_W     ($bits(cplx_t))
	) i_bank1 (
		.clk   (clk),
		.we    (we1),
		.waddr (waddr1),
		.wdata (wdata),
		.raddr (raddr1),
		.rdata (rdata1)
	);

	// ------------------------------------------------------------
	// read side and output buffer
	// ------------------------------------------------------------
	dct_rot_read_ctrl i_read_ctrl (
		.clk        (clk),
		.rst_n_sync (rst_n_sync),
		.frame_info (frame_info),
		.pop        (pop),
		.raddr0     (raddr0),
		.raddr1     (raddr1),
		.tag        (tag),
		.push       (push),
		.read_done  (read_done)
	);

	dct_rot_out_buf i_out_buf (
		.clk          (clk),
		.rst_n_sync   (rst_n_sync),
		.push         (push),
		.tag          (tag),
		.rdata0       (rdata0),
		.rdata1       (rdata1),
		.source_valid (source_valid),
		.source_ready (source_ready),
		.source_data  (source_data),
		.pop          (pop)
	);

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
/*
 * testbench clock and reset generator
 * free running clock, synchronous reset held for a set number of cycles
 */
`default_nettype none

module tb_clk_gen #(
	parameter int PERIOD = 10,
	parameter int RST_CYCLES = 16
) (
	output logic clk,
	output logic rst_n_sync
);

	initial
	begin
		clk = 1'b0;
		forever
			#(PERIOD / 2) clk = ~clk;
	end

	// release on a falling edge, away from the sampling edge
	initial
	begin
		rst_n_sync = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n_sync = 1'b1;
	end

endmodule

`default_nettype wire

// File: tb_dct_rot.sv
/*
 * testbench for the dct rotation reorder buffer
 * frame stimulus in bit reversed order, random source back-pressure
 * reference model of the paired natural order readout
 * output comparator, sink hold monitor, watchdog
 */
`default_nettype none

module tb_dct_rot
	import dct_rot_pkg::*;
;

	localparam int NUM_FRAMES = 6;
	localparam int MAX_N = 1 << MAX_LOG2;

	logic clk;
	logic rst_n_sync;
	logic sink_valid;
	logic sink_ready;
	logic sink_sop;
	cplx_t sink_data;
	size_log2_t fft_size_log2;
	logic source_valid;
	logic source_ready;
	pair_beat_t source_data;

	// log2 N per frame, last two back to back under random ready
	int frame_lg [NUM_FRAMES] = '{5, 6, 8, 11, 5, 7};
	// samples in arrival order, per frame
	cplx_t in_mem [NUM_FRAMES][MAX_N];
	logic rand_ready;
	int cur_frame;
	int cur_k;
	int beats_seen;
	pair_beat_t exp_beat;
	// sink hold monitor
	int in_cnt;
	int in_n;
	logic hold;

	tb_clk_gen #(
		.PERIOD     (10),
		.RST_CYCLES (16)
	) i_clk_gen (
		.clk        (clk),
		.rst_n_sync (rst_n_sync)
	);

	dct_rot_top i_dut (
		.clk           (clk),
		.rst_n_sync    (rst_n_sync),
		.sink_valid    (sink_valid),
		.sink_ready    (sink_ready),
		.sink_sop      (sink_sop),
		.sink_data     (sink_data),
		.fft_size_log2 (fft_size_log2),
		.source_valid  (source_valid),
		.source_ready  (source_ready),
		.source_data   (source_data)
	);

	// ------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------
	function automatic int reverse_bits(int v, int l);
		int r;
		r = 0;
		for (int j = 0; j < l; j++)
			r = r | (((v >> j) & 1) << (l - 1 - j));
		return r;
	endfunction

	// F(i) is the sample that arrived at count bitrev(i)
	function automatic pair_beat_t expected_beat(int f, int k);
		pair_beat_t b;
		int n;
		n = 1 << frame_lg[f];
		b.fwd = in_mem[f][reverse_bits(k, frame_lg[f])];
		b.rev = in_mem[f][reverse_bits((n - k) % n, frame_lg[f])];
		b.sop = (k == 0);
		b.eop = (k == n - 1);
		return b;
	endfunction

	function automatic int frame_total();
		int t;
		t = 0;
		for (int f = 0; f < NUM_FRAMES; f++)
			t += 1 << frame_lg[f];
		return t;
	endfunction

	// ------------------------------------------------------------
	// compare tasks
	// ------------------------------------------------------------
	task automatic compare_beat(string name, pair_beat_t got, pair_beat_t exp);
		if (got !== exp)
		begin
			$display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
			$display("=== FAIL ===");
			$fatal(1, "output beat mismatch");
		end
	endtask

	task automatic compare_count(string name, int got, int exp);
		if (got != exp)
		begin
			$display("ERR t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
			$display("=== FAIL ===");
			$fatal(1, "beat count mismatch");
		end
	endtask

	task automatic compare_bit(string name, logic got, logic exp);
		if (got !== exp)
		begin
			$display("ERR t=%0t %s got=%b exp=%b", $time, name, got, exp);
			$display("=== FAIL ===");
			$fatal(1, "control bit mismatch");
		end
	endtask

	// one frame in arrival order, entered and left on a falling edge
	task automatic send_frame(int f);
		cplx_t v;
		for (int c = 0; c < (1 << frame_lg[f]); c++)
		begin
			v.re = sample_t'($urandom);
			v.im = sample_t'($urandom);
			in_mem[f][c] = v;
			sink_valid = 1'b1;
			sink_sop = (c == 0);
			sink_data = v;
			fft_size_log2 = size_log2_t'(frame_lg[f]);
			@(posedge clk);
			while (!sink_ready)
				@(posedge clk);
			@(negedge clk);
		end
		sink_valid = 1'b0;
		sink_sop = 1'b0;
	endtask

	// ------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------
	initial
	begin
		void'($urandom(68));
		sink_valid = 1'b0;
		sink_sop = 1'b0;
		sink_data = '0;
		fft_size_log2 = size_log2_t'(MIN_LOG2);
		rand_ready = 1'b0;
		// both handshake outputs quiet during reset
		repeat (8) @(negedge clk);
		compare_bit("sink_ready", sink_ready, 1'b0);
		compare_bit("source_valid", source_valid, 1'b0);
		wait (rst_n_sync);
		@(negedge clk);
		compare_bit("source_valid", source_valid, 1'b0);
		while (!sink_ready)
			@(negedge clk);
		for (int f = 0; f < NUM_FRAMES; f++)
		begin
			// back-pressure from the fifth frame on
			if (f == 4)
				rand_ready = 1'b1;
			send_frame(f);
		end
		wait (cur_frame == NUM_FRAMES);
		// quiet period, no further beat may come out
		repeat (32) @(negedge clk);
		compare_count("beats_seen", beats_seen, frame_total());
		compare_bit("source_valid", source_valid, 1'b0);
		$display("=== PASS ===");
		$finish;
	end

	// source ready, random or held high
	initial
	begin
		source_ready = 1'b0;
		forever
		begin
			@(negedge clk);
			source_ready = rand_ready ? (($urandom % 4) != 0) : 1'b1;
		end
	end

	// ------------------------------------------------------------
	// output comparator
	// ------------------------------------------------------------
	initial
	begin
		cur_frame = 0;
		cur_k = 0;
		beats_seen = 0;
	end

	always @(posedge clk)
	begin
		if (rst_n_sync && source_valid && source_ready)
		begin
			beats_seen++;
			// beats past the last frame only add to the total
			if (cur_frame < NUM_FRAMES)
			begin
				exp_beat = expected_beat(cur_frame, cur_k);
				compare_beat("source_data", source_data, exp_beat);
				if (cur_k == (1 << frame_lg[cur_frame]) - 1)
				begin
					cur_frame++;
					cur_k = 0;
				end
				else
					cur_k++;
			end
		end
	end

	// ------------------------------------------------------------
	// sink held off between hand-off and read_done
	// ------------------------------------------------------------
	initial
	begin
		in_cnt = 0;
		in_n = 0;
		hold = 1'b0;
	end

	always @(posedge clk)
	begin
		if (hold)
		begin
			compare_bit("sink_ready", sink_ready, 1'b0);
			if (i_dut.read_done)
				hold = 1'b0;
		end
		if (sink_valid && sink_ready)
		begin
			if (sink_sop)
			begin
				in_n = 1 << fft_size_log2;
				in_cnt = 1;
			end
			else
				in_cnt++;
			// last sample of the frame, ready drops from the next edge
			if (in_cnt == in_n)
				hold = 1'b1;
		end
	end

	// ------------------------------------------------------------
	// watchdog
	// ------------------------------------------------------------
	initial
	begin
		repeat (frame_total() * 20 + 2000) @(posedge clk);
		$display("timeout, the output stream did not complete in time");
		$display("=== FAIL ===");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

// File: project.f
dct_rot_pkg.sv
dct_rot_bank_ram.sv
dct_rot_write_ctrl.sv
dct_rot_read_ctrl.sv
dct_rot_out_buf.sv
dct_rot_top.sv
tb_clk_gen.sv
tb_dct_rot.sv
